// File: src.f
logic/cache_pkg.sv
logic/cache_ram.sv
logic/cache_lookup.sv
logic/cache_miss_ctrl.sv
logic/cache_data_path.sv
logic/dcache_top.sv
dv/dcache_assert.sv
dv/dcache_tb.sv

// File: run.sh
#!/bin/sh
# Build the testbench with Verilator, run it, and judge the run from its log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module dcache_tb -f src.f -o dcache_sim \
    && ./obj_dir/dcache_sim > sim.log 2>&1 \
    || echo "Build or simulation did not complete"
grep -q "Regression passed" sim.log 2>/dev/null && echo "PASS" || { echo "FAIL"; exit 1; }

// File: dv/dcache_tb.sv
module dcache_tb;

    localparam int num_tests = 13;
    localparam int stall_limit = 200;
    localparam int rvalid_limit = 8;

    logic             clk;
    logic             rst;
    logic             f_req;
    logic             f_we;
    cache_pkg::addr_t f_addr;
    cache_pkg::word_t f_wdata;
    logic             f_stall;
    cache_pkg::word_t f_rdata;
    logic             f_rvalid;
    logic             b_req;
    logic             b_we;
    cache_pkg::addr_t b_addr;
    cache_pkg::word_t b_wdata;
    logic             b_valid;
    cache_pkg::word_t b_rdata;

    // Table row with store flag, address, store data, expected load word and backing reads
    typedef struct packed {
        logic             store;
        cache_pkg::addr_t addr;
        cache_pkg::word_t wdata;
        cache_pkg::word_t exp_word;
        logic [7:0]       exp_reads;
    } row_t;

    row_t             rows [num_tests];
    cache_pkg::word_t backing [cache_pkg::addr_t];
    cache_pkg::addr_t rd_log [$];
    int               wr_count;
    cache_pkg::addr_t wr_addr;
    cache_pkg::word_t wr_data;
    int               err_count;
    logic             timed_out;

    dcache_top dut (
        .clk      (clk),
        .rst      (rst),
        .f_req    (f_req),
        .f_we     (f_we),
        .f_addr   (f_addr),
        .f_wdata  (f_wdata),
        .f_stall  (f_stall),
        .f_rdata  (f_rdata),
        .f_rvalid (f_rvalid),
        .b_req    (b_req),
        .b_we     (b_we),
        .b_addr   (b_addr),
        .b_wdata  (b_wdata),
        .b_valid  (b_valid),
        .b_rdata  (b_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Untouched backing words read as the low address bits with a fixed pattern
    function automatic cache_pkg::word_t init_word(cache_pkg::addr_t a);
        return a[23:0] ^ 24'h5a5a5a;
    endfunction

    function automatic cache_pkg::word_t read_word(cache_pkg::addr_t a);
        if (backing.exists(a)) begin
            return backing[a];
        end
        return init_word(a);
    endfunction

    task automatic check_value(string name, logic [63:0] got, logic [63:0] exp);
        if (got !== exp) begin
            $display("Fail at %0t: %s is %h, expected %h", $time, name, got, exp);
            err_count++;
        end
    endtask

    // Called right after a falling edge and returns once f_stall is low
    task automatic wait_stall_low(int n);
        int cycles;
        cycles = 0;
        #1;
        while (f_stall && cycles < stall_limit) begin
            @(negedge clk);
            #1;
            cycles++;
        end
        if (f_stall) begin
            $display("Timeout in test %0d: f_stall never went low", n);
            timed_out = 1'b1;
        end
    endtask

    task automatic wait_rvalid(int n);
        int cycles;
        cycles = 0;
        #1;
        while (!f_rvalid && cycles < rvalid_limit) begin
            @(negedge clk);
            #1;
            cycles++;
        end
        if (!f_rvalid) begin
            $display("Timeout in test %0d: no f_rvalid after the load was taken", n);
            timed_out = 1'b1;
        end
    endtask

    // Backing memory answers one request at a time after 1 to 4 cycles
    initial begin : backing_model
        int unsigned      wait_left;
        logic             p_we;
        cache_pkg::addr_t p_addr;
        cache_pkg::word_t p_data;
        void'($urandom(32'h6328_b26d));
        wait_left = 0;
        wr_count = 0;
        b_valid = 1'b0;
        b_rdata = '0;
        forever begin
            @(negedge clk);
            b_valid = 1'b0;
            if (wait_left != 0) begin
                wait_left--;
                if (wait_left == 0) begin
                    b_valid = 1'b1;
                    if (p_we) begin
                        backing[p_addr] = p_data;
                    end else begin
                        b_rdata = read_word(p_addr);
                    end
                end
            end else if (b_req) begin
                p_we = b_we;
                p_addr = b_addr;
                p_data = b_wdata;
                wait_left = 32'd1 + ($urandom % 32'd4);
                if (b_we) begin
                    wr_count++;
                    wr_addr = b_addr;
                    wr_data = b_wdata;
                end else begin
                    rd_log.push_back(b_addr);
                end
            end
        end
    end

    initial begin : main
        int          errs_before;
        int          reads_before;
        int          writes_before;
        int          failed_tests;
        int          tests_run;
        rst = 1'b1;
        f_req = 1'b0;
        f_we = 1'b0;
        f_addr = '0;
        f_wdata = '0;
        err_count = 0;
        failed_tests = 0;
        tests_run = 0;
        timed_out = 1'b0;
        // Line 9 is shared by two tags and line 3 is first touched by a store miss
        rows[0] = '{1'b0, 48'h12_3456_7893, 24'h0, init_word(48'h12_3456_7893), 8'd16};
        rows[1] = '{1'b0, 48'h12_3456_7890, 24'h0, init_word(48'h12_3456_7890), 8'd0};
        rows[2] = '{1'b0, 48'h12_3456_789f, 24'h0, init_word(48'h12_3456_789f), 8'd0};
        rows[3] = '{1'b1, 48'h12_3456_7895, 24'hc0ffee, 24'h0, 8'd0};
        rows[4] = '{1'b0, 48'h12_3456_7895, 24'h0, 24'hc0ffee, 8'd0};
        rows[5] = '{1'b1, 48'hab_cdef_0137, 24'h13579b, 24'h0, 8'd0};
        rows[6] = '{1'b0, 48'hab_cdef_0137, 24'h0, 24'h13579b, 8'd16};
        rows[7] = '{1'b0, 48'h77_0000_0092, 24'h0, init_word(48'h77_0000_0092), 8'd16};
        rows[8] = '{1'b0, 48'h12_3456_7895, 24'h0, 24'hc0ffee, 8'd16};
        rows[9] = '{1'b0, 48'h77_0000_009a, 24'h0, init_word(48'h77_0000_009a), 8'd16};
        rows[10] = '{1'b0, 48'h12_3456_7890, 24'h0, init_word(48'h12_3456_7890), 8'd16};
        rows[11] = '{1'b0, 48'h12_3456_7891, 24'h0, init_word(48'h12_3456_7891), 8'd0};
        rows[12] = '{1'b0, 48'hab_cdef_0130, 24'h0, init_word(48'hab_cdef_0130), 8'd0};
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        for (int i = 0; i < num_tests && !timed_out; i++) begin
            errs_before = err_count;
            reads_before = rd_log.size();
            writes_before = wr_count;
            @(negedge clk);
            f_req = 1'b1;
            f_we = rows[i].store;
            f_addr = rows[i].addr;
            f_wdata = rows[i].wdata;
            wait_stall_low(i);
            @(negedge clk);
            f_req = 1'b0;
            if (rows[i].store) begin
                wait_stall_low(i);
                check_value("b_addr", 64'(wr_addr), 64'(rows[i].addr));
                check_value("b_wdata", 64'(wr_data), 64'(rows[i].wdata));
            end else begin
                wait_rvalid(i);
                check_value("f_rdata", 64'(f_rdata), 64'(rows[i].exp_word));
                // The load result is a single-cycle pulse
                @(negedge clk);
                #1;
                check_value("f_rvalid", 64'(f_rvalid), 64'(0));
            end
            check_value("backing reads", 64'(rd_log.size() - reads_before),
                64'(rows[i].exp_reads));
            check_value("backing writes", 64'(wr_count - writes_before), 64'(rows[i].store));
            // Refill walks the line from offset 0 upward
            for (int k = 0; k < int'(rows[i].exp_reads) && reads_before + k < rd_log.size();
                    k++) begin
                check_value("b_addr", 64'(rd_log[reads_before + k]),
                    64'({rows[i].addr[47:4], 4'(k)}));
            end
            tests_run++;
            if (err_count != errs_before || timed_out) begin
                failed_tests++;
            end
            $display("test %0d %s %h: %s", i, rows[i].store ? "store" : "load",
                rows[i].addr, (err_count == errs_before && !timed_out) ? "ok" : "mismatch");
        end
        $display("%0d tests run, %0d failed, %0d check errors", tests_run, failed_tests,
            err_count);
        if (err_count == 0 && !timed_out) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// File: dv/dcache_assert.sv
module dcache_assert (
    input logic clk,
    input logic rst,
    input logic f_stall,
    input logic b_req,
    input logic b_we,
    input logic b_valid
);

    logic outstanding;

    // High from the cycle after b_req until its b_valid
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            outstanding <= 1'b0;
        end else if (b_valid) begin
            outstanding <= 1'b0;
        end else if (b_req) begin
            outstanding <= 1'b1;
        end
    end

    single_request: assert property (@(posedge clk) disable iff (rst) outstanding |-> !b_req)
        else $error("b_req raised while a backing request is outstanding");

    idle_after_reset: assert property (@(posedge clk) $fell(rst) |-> !f_stall)
        else $error("f_stall high right after reset");

    write_with_req: assert property (@(posedge clk) disable iff (rst) b_we |-> b_req)
        else $error("b_we high without b_req");

endmodule

bind cache_miss_ctrl dcache_assert u_assert (
    .clk     (clk),
    .rst     (rst),
    .f_stall (f_stall),
    .b_req   (b_req),
    .b_we    (b_we),
    .b_valid (b_valid)
);

// File: logic/dcache_top.sv
module dcache_top (
    input  logic             clk,
    input  logic             rst,
    input  logic             f_req,
    input  logic             f_we,
    input  cache_pkg::addr_t f_addr,
    input  cache_pkg::word_t f_wdata,
    output logic             f_stall,
    output cache_pkg::word_t f_rdata,
    output logic             f_rvalid,
    output logic             b_req,
    output logic             b_we,
    output cache_pkg::addr_t b_addr,
    output cache_pkg::word_t b_wdata,
    input  logic             b_valid,
    input  cache_pkg::word_t b_rdata
);

    logic                  hit;
    cache_pkg::idx_t       idx;
    cache_pkg::off_t       off;
    cache_pkg::tag_t       tag;
    logic                  busy;
    logic                  tag_we;
    cache_pkg::idx_t       tag_idx;
    cache_pkg::tag_entry_t tag_wr;
    logic                  fill_we;
    cache_pkg::off_t       fill_off;
    cache_pkg::word_t      fill_word;

    // Address decode and hit check
    cache_lookup u_lookup (
        .clk     (clk),
        .rst     (rst),
        .f_addr  (f_addr),
        .tag_we  (tag_we),
        .tag_idx (tag_idx),
        .tag_wr  (tag_wr),
        .idx     (idx),
        .off     (off),
        .tag     (tag),
        .hit     (hit)
    );

    // Stall, refill and write-through sequencing
    cache_miss_ctrl u_miss_ctrl (
        .clk       (clk),
        .rst       (rst),
        .f_req     (f_req),
        .f_we      (f_we),
        .f_addr    (f_addr),
        .f_wdata   (f_wdata),
        .hit       (hit),
        .idx       (idx),
        .tag       (tag),
        .f_stall   (f_stall),
        .busy      (busy),
        .tag_we    (tag_we),
        .tag_idx   (tag_idx),
        .tag_wr    (tag_wr),
        .fill_we   (fill_we),
        .fill_off  (fill_off),
        .fill_word (fill_word),
        .b_req     (b_req),
        .b_we      (b_we),
        .b_addr    (b_addr),
        .b_wdata   (b_wdata),
        .b_valid   (b_valid),
        .b_rdata   (b_rdata)
    );

    // Data store and load result
    cache_data_path u_data_path (
        .clk       (clk),
        .rst       (rst),
        .f_req     (f_req),
        .f_we      (f_we),
        .f_wdata   (f_wdata),
        .hit       (hit),
        .busy      (busy),
        .f_stall   (f_stall),
        .idx       (idx),
        .off       (off),
        .fill_we   (fill_we),
        .fill_off  (fill_off),
        .fill_word (fill_word),
        .f_rdata   (f_rdata),
        .f_rvalid  (f_rvalid)
    );

endmodule

// File: logic/cache_data_path.sv
module cache_data_path (
    input  logic             clk,
    input  logic             rst,
    input  logic             f_req,
    input  logic             f_we,
    input  cache_pkg::word_t f_wdata,
    input  logic             hit,
    input  logic             busy,
    input  logic             f_stall,
    input  cache_pkg::idx_t  idx,
    input  cache_pkg::off_t  off,
    input  logic             fill_we,
    input  cache_pkg::off_t  fill_off,
    input  cache_pkg::word_t fill_word,
    output cache_pkg::word_t f_rdata,
    output logic             f_rvalid
);

    logic [cache_pkg::idx_bits+cache_pkg::off_bits-1:0] waddr;
    cache_pkg::word_t wdata;
    cache_pkg::word_t rd_word;
    logic             we;
    logic             store_hit;
    logic             load_take;

    assign store_hit = f_req && f_we && !f_stall && hit;
    assign load_take = f_req && !f_we && hit && !busy;

    // Refill beats use the front index that the core holds during the stall
    assign we = fill_we || store_hit;
    assign waddr = fill_we ? {idx, fill_off} : {idx, off};
    assign wdata = fill_we ? fill_word : f_wdata;

    cache_ram #(
        .depth     (cache_pkg::num_lines * cache_pkg::line_words),
        .payload_t (cache_pkg::word_t)
    ) u_data_ram (
        .clk   (clk),
        .rst   (rst),
        .we    (we),
        .waddr (waddr),
        .raddr ({idx, off}),
        .wdata (wdata),
        .rdata (rd_word)
    );

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            f_rvalid <= 1'b0;
        end else begin
            f_rvalid <= load_take;
        end
    end

    // Load result holds until the next accepted load
    always_ff @(posedge clk) begin
        if (load_take) begin
            f_rdata <= rd_word;
        end
    end

endmodule

// File: logic/cache_miss_ctrl.sv
module cache_miss_ctrl (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   f_req,
    input  logic                   f_we,
    input  cache_pkg::addr_t       f_addr,
    input  cache_pkg::word_t       f_wdata,
    input  logic                   hit,
    input  cache_pkg::idx_t        idx,
    input  cache_pkg::tag_t        tag,
    output logic                   f_stall,
    output logic                   busy,
    output logic                   tag_we,
    output cache_pkg::idx_t        tag_idx,
    output cache_pkg::tag_entry_t  tag_wr,
    output logic                   fill_we,
    output cache_pkg::off_t        fill_off,
    output cache_pkg::word_t       fill_word,
    output logic                   b_req,
    output logic                   b_we,
    output cache_pkg::addr_t       b_addr,
    output cache_pkg::word_t       b_wdata,
    input  logic                   b_valid,
    input  cache_pkg::word_t       b_rdata
);

    typedef enum logic [1:0] {
        st_idle,
        st_refill,
        st_store
    } state_t;

    state_t           state;
    logic             issued;
    cache_pkg::off_t  beat;
    cache_pkg::idx_t  miss_idx;
    cache_pkg::tag_t  miss_tag;
    cache_pkg::addr_t st_addr;
    cache_pkg::word_t st_data;
    logic             load_miss;
    logic             store_acc;

    assign busy = (state != st_idle);
    assign load_miss = f_req && !f_we && !hit;
    assign store_acc = !busy && f_req && f_we;

    // Stores stall only while the controller is busy
    assign f_stall = busy || load_miss;

    // One request per beat until the memory has taken it
    assign b_req = busy && !issued;
    assign b_we = (state == st_store) && !issued;
    assign b_addr = (state == st_store) ? st_addr : {miss_tag, miss_idx, beat};
    assign b_wdata = st_data;

    // Each returned refill word goes straight into the data store
    assign fill_we = (state == st_refill) && b_valid;
    assign fill_off = beat;
    assign fill_word = b_rdata;

    // Tag entry commits with the last beat
    assign tag_we = fill_we && (beat == '1);
    assign tag_idx = miss_idx;
    assign tag_wr = '{valid: 1'b1, tag: miss_tag};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state  <= st_idle;
            issued <= 1'b0;
            beat   <= '0;
        end else begin
            case (state)
                st_idle: begin
                    issued <= 1'b0;
                    beat   <= '0;
                    if (store_acc) begin
                        state <= st_store;
                    end else if (load_miss) begin
                        state <= st_refill;
                    end
                end
                st_refill: begin
                    if (b_valid) begin
                        issued <= 1'b0;
                        beat   <= beat + 1'b1;
                        if (beat == '1) begin
                            state <= st_idle;
                        end
                    end else if (b_req) begin
                        issued <= 1'b1;
                    end
                end
                st_store: begin
                    if (b_valid) begin
                        issued <= 1'b0;
                        state  <= st_idle;
                    end else if (b_req) begin
                        issued <= 1'b1;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // Miss line and store buffer follow the front while idle and freeze once busy
    always_ff @(posedge clk) begin
        if (!busy) begin
            miss_idx <= idx;
            miss_tag <= tag;
            st_addr  <= f_addr;
            st_data  <= f_wdata;
        end
    end

endmodule

// File: logic/cache_lookup.sv
module cache_lookup (
    input  logic                   clk,
    input  logic                   rst,
    input  cache_pkg::addr_t       f_addr,
    input  logic                   tag_we,
    input  cache_pkg::idx_t        tag_idx,
    input  cache_pkg::tag_entry_t  tag_wr,
    output cache_pkg::idx_t        idx,
    output cache_pkg::off_t        off,
    output cache_pkg::tag_t        tag,
    output logic                   hit
);

    cache_pkg::tag_entry_t entry;

    // The offset sits in the low bits with index and tag above it
    assign off = f_addr[cache_pkg::off_bits-1:0];
    assign idx = f_addr[cache_pkg::off_bits +: cache_pkg::idx_bits];
    assign tag = f_addr[cache_pkg::addr_w-1 -: cache_pkg::tag_bits];

    // Tag store, one entry per line
    // Written only when a refill completes
    cache_ram #(
        .depth     (cache_pkg::num_lines),
        .payload_t (cache_pkg::tag_entry_t)
    ) u_tag_ram (
        .clk   (clk),
        .rst   (rst),
        .we    (tag_we),
        .waddr (tag_idx),
        .raddr (idx),
        .wdata (tag_wr),
        .rdata (entry)
    );

    // Hit needs a valid line holding the same tag
    assign hit = entry.valid && (entry.tag == tag);

endmodule

// File: logic/cache_ram.sv
module cache_ram #(
    parameter int depth = 16,
    parameter type payload_t = logic
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     we,
    input  logic [$clog2(depth)-1:0] waddr,
    input  logic [$clog2(depth)-1:0] raddr,
    input  payload_t                 wdata,
    output payload_t                 rdata
);

    payload_t mem [depth];

    // Combinational read with the result register in the caller
    assign rdata = mem[raddr];

    // Reset zeroes every entry so tag entries come up invalid
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < depth; i++) begin
                mem[i] <= '0;
            end
        end else if (we) begin
            mem[waddr] <= wdata;
        end
    end

endmodule

// File: logic/cache_pkg.sv
package cache_pkg;

    // Core word and address widths
    // Addresses count words, not bytes
    localparam int addr_w = 48;
    localparam int word_w = 24;

    // Direct-mapped geometry with 16 lines of 16 words
    localparam int off_bits = 4;
    localparam int idx_bits = 4;
    localparam int tag_bits = addr_w - off_bits - idx_bits;

    localparam int line_words = 1 << off_bits;
    localparam int num_lines = 1 << idx_bits;

    // Word address as seen by the core
    typedef logic [addr_w-1:0] addr_t;

    // One cached data word
    typedef logic [word_w-1:0] word_t;

    // Address fields
    typedef logic [idx_bits-1:0] idx_t;
    typedef logic [off_bits-1:0] off_t;
    typedef logic [tag_bits-1:0] tag_t;

    // Per-line metadata kept in the tag store
    // All zero means invalid, which is the reset value of the store
    typedef struct packed {
        logic valid;
        tag_t tag;
    } tag_entry_t;

endpackage
